// File: src/dcache_pkg.sv
//##############################
// data cache shared types
//##############################
package dcache_pkg;

    // geometry
    localparam int TAG_W     = 26;
    localparam int IDX_W     = 3;
    localparam int WAYS      = 2;
    localparam int SETS      = 8;
    localparam int BLK_WORDS = 2;

    typedef logic [31:0] word_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic             blkoff;   // word within block
        logic [1:0]       bytoff;
    } addr_t;

    // one way of a set, 92 bits
    typedef struct packed {
        logic                    valid;
        logic                    dirty;
        logic [TAG_W-1:0]        tag;
        word_t [BLK_WORDS-1:0]   data;
    } frame_t;

    typedef struct packed {
        frame_t [WAYS-1:0] frame;
        logic              lru;     // way to replace next
    } set_t;

    // datapath side
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;
    } dp_rsp_t;

    // single word transfer towards the bus port
    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t data;
    } mem_req_t;

    typedef enum logic [3:0] {
        IDLE, WB1, WB2, RD1, RD2, FL_SCAN, FL1, FL2, DONE
    } cache_state_t;

endpackage

// File: src/dcache_store.sv
`timescale 1ns/1ps
//##############################
// data cache storage
//##############################
module dcache_store import dcache_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  addr_t      lookup_addr,
    input  logic [3:0] flush_ptr,
    input  logic       wr_word,
    input  word_t      wr_data,
    input  logic       fill_word,
    input  logic       fill_sel,
    input  word_t      fill_data,
    input  logic       fill_tag,
    input  logic       clr_dirty_victim,
    input  logic       clr_dirty_flush,
    input  logic       touch,
    output logic       hit,
    output logic       hit_way,
    output word_t      hit_data,
    output frame_t     victim,
    output frame_t     flush_frame
);

    set_t sets [SETS];

    set_t             cur_set;
    logic [IDX_W-1:0] idx;
    logic             vway;
    logic [IDX_W-1:0] fidx;
    logic             fway;

    assign idx     = lookup_addr.idx;
    assign cur_set = sets[idx];
    assign vway    = cur_set.lru;       // victim is whatever lru names

    // frame 0..15 maps to set ptr[3:1], way ptr[0]
    assign fidx = flush_ptr[3:1];
    assign fway = flush_ptr[0];

    // tag compare across both ways
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (cur_set.frame[w].valid && cur_set.frame[w].tag == lookup_addr.tag) begin
                hit     = 1'b1;
                hit_way = w[0];
            end
        end
    end

    assign hit_data    = cur_set.frame[hit_way].data[lookup_addr.blkoff];
    assign victim      = cur_set.frame[vway];
    assign flush_frame = sets[fidx].frame[fway];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < SETS; s++) begin
                sets[s] <= '0;                  // all frames invalid
            end
        end else begin
            // store hit, marks the line dirty
            if (wr_word) begin
                sets[idx].frame[hit_way].data[lookup_addr.blkoff] <= wr_data;
                sets[idx].frame[hit_way].dirty <= 1'b1;
            end

            // refill goes into the victim way
            if (fill_word) begin
                sets[idx].frame[vway].data[fill_sel] <= fill_data;
            end
            if (fill_tag) begin
                sets[idx].frame[vway].tag   <= lookup_addr.tag;
                sets[idx].frame[vway].valid <= 1'b1;
                sets[idx].frame[vway].dirty <= 1'b0;
            end
            if (clr_dirty_victim) begin
                sets[idx].frame[vway].dirty <= 1'b0;   // written back
            end

            if (clr_dirty_flush) begin
                sets[fidx].frame[fway].dirty <= 1'b0;
            end

            // replace the other way next time
            if (touch) begin
                sets[idx].lru <= ~hit_way;
            end
        end
    end

endmodule

// File: src/dcache_fsm.sv
`timescale 1ns/1ps
//##############################
// data cache controller
//##############################
module dcache_fsm import dcache_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  dp_req_t    dp_req,
    input  logic       halt,
    output dp_rsp_t    dp_rsp,
    output logic       flushed,
    output word_t      hit_count,
    output mem_req_t   mem_req,
    input  logic       mem_done,
    input  word_t      mem_rdata,
    output addr_t      lookup_addr,
    output logic [3:0] flush_ptr,
    output logic       wr_word,
    output word_t      wr_data,
    output logic       fill_word,
    output logic       fill_sel,
    output word_t      fill_data,
    output logic       fill_tag,
    output logic       clr_dirty_victim,
    output logic       clr_dirty_flush,
    output logic       touch,
    input  logic       hit,
    input  word_t      hit_data,
    input  frame_t     victim,
    input  frame_t     flush_frame
);

    cache_state_t state, next_state;
    logic [3:0]   next_ptr;
    word_t        next_count;
    logic         refill_last;  // previous cycle finished RD2
    logic         req;

    // word address inside a block
    function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                       input logic [IDX_W-1:0] idx,
                                       input logic             wsel);
        addr_t a;
        a.tag    = tag;
        a.idx    = idx;
        a.blkoff = wsel;
        a.bytoff = 2'b00;
        return word_t'(a);
    endfunction

    assign req         = dp_req.ren | dp_req.wen;
    assign lookup_addr = dp_req.addr;
    assign wr_data     = dp_req.wdata;
    assign fill_data   = mem_rdata;

    always_comb begin
        next_state       = state;
        next_ptr         = flush_ptr;
        next_count       = hit_count;
        dp_rsp           = '0;
        mem_req          = '0;
        wr_word          = 1'b0;
        fill_word        = 1'b0;
        fill_sel         = 1'b0;
        fill_tag         = 1'b0;
        clr_dirty_victim = 1'b0;
        clr_dirty_flush  = 1'b0;
        touch            = 1'b0;
        flushed          = 1'b0;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = FL_SCAN;
                end else if (req) begin
                    if (hit) begin
                        dp_rsp.hit   = 1'b1;
                        dp_rsp.rdata = hit_data;
                        wr_word      = dp_req.wen;
                        touch        = 1'b1;
                        if (!refill_last) next_count = hit_count + 32'd1;
                    end else if (victim.valid && victim.dirty) begin
                        next_state = WB1;
                    end else begin
                        next_state = RD1;
                    end
                end
            end
            WB1, WB2: begin                 // evict dirty victim, word 0 then 1
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = blk_addr(victim.tag, lookup_addr.idx, state == WB2);
                mem_req.data  = victim.data[state == WB2];
                if (mem_done) begin
                    clr_dirty_victim = (state == WB2);
                    next_state       = (state == WB1) ? WB2 : RD1;
                end
            end
            RD1, RD2: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = blk_addr(dp_req.addr.tag, dp_req.addr.idx, state == RD2);
                if (mem_done) begin
                    fill_word  = 1'b1;
                    fill_sel   = (state == RD2);
                    fill_tag   = (state == RD2);    // block complete
                    next_state = (state == RD1) ? RD2 : IDLE;
                end
            end
            FL_SCAN: begin
                if (flush_frame.valid && flush_frame.dirty) begin
                    next_state = FL1;
                end else if (flush_ptr == 4'd15) begin
                    next_state = DONE;
                end else begin
                    next_ptr = flush_ptr + 4'd1;
                end
            end
            FL1, FL2: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = blk_addr(flush_frame.tag, flush_ptr[3:1], state == FL2);
                mem_req.data  = flush_frame.data[state == FL2];
                if (mem_done) begin
                    clr_dirty_flush = (state == FL2);
                    next_state      = (state == FL1) ? FL2 : FL_SCAN; // rescan, now clean
                end
            end
            DONE:    flushed = 1'b1;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE;
            flush_ptr   <= '0;
            hit_count   <= '0;
            refill_last <= 1'b0;
        end else begin
            state       <= next_state;
            flush_ptr   <= next_ptr;
            hit_count   <= next_count;
            refill_last <= (state == RD2) && mem_done;
        end
    end

endmodule

// File: src/wb_word_port.sv
`timescale 1ns/1ps
//##############################
// wishbone word master
//##############################
module wb_word_port import dcache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  mem_req_t mem_req,
    output logic     mem_done,
    output word_t    mem_rdata,
    output logic     wb_cyc,
    output logic     wb_stb,
    output logic     wb_we,
    output word_t    wb_adr,
    output word_t    wb_dat_o,
    input  word_t    wb_dat_i,
    input  logic     wb_ack
);

    logic busy;     // held from start through the mem_done cycle
    logic start;

    assign start = mem_req.valid && !busy && !wb_stb;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            busy     <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (wb_stb) begin
                if (wb_ack) begin
                    wb_cyc   <= 1'b0;
                    wb_stb   <= 1'b0;
                    mem_done <= 1'b1;
                end
            end else if (mem_done) begin
                busy <= 1'b0;           // controller moves on this cycle
            end else if (start) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                busy   <= 1'b1;
            end
        end
    end

    // address, data and read capture
    always_ff @(posedge CLK) begin
        if (start) begin
            wb_we    <= mem_req.we;
            wb_adr   <= mem_req.addr;
            wb_dat_o <= mem_req.data;
        end
        if (wb_stb && wb_ack) mem_rdata <= wb_dat_i;
    end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps
//##############################
// data cache top
//##############################
module dcache_top import dcache_pkg::*; (
    input  logic    CLK,
    input  logic    nRST,
    input  dp_req_t dp_req,
    input  logic    halt,
    output dp_rsp_t dp_rsp,
    output logic    flushed,
    output word_t   hit_count,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output word_t   wb_adr,
    output word_t   wb_dat_o,
    input  word_t   wb_dat_i,
    input  logic    wb_ack
);

    // controller <-> storage
    addr_t      lookup_addr;
    logic [3:0] flush_ptr;
    logic       wr_word;
    word_t      wr_data;
    logic       fill_word;
    logic       fill_sel;
    word_t      fill_data;
    logic       fill_tag;
    logic       clr_dirty_victim;
    logic       clr_dirty_flush;
    logic       touch;
    logic       hit;
    word_t      hit_data;
    frame_t     victim;
    frame_t     flush_frame;

    // controller <-> bus port
    mem_req_t   mem_req;
    logic       mem_done;
    word_t      mem_rdata;

    dcache_store store (.*, .hit_way());     // way used only inside the store

    dcache_fsm fsm (.*);

    wb_word_port bus (.*);

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps
//##############################
// testbench clock and reset
//##############################
module clock_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;      // 8 ns period
    end

    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        @(negedge CLK);             // release away from the active edge
        nRST = 1'b1;
    end

endmodule

// File: bench/dcache_assertions.sv
`timescale 1ns/1ps
//##############################
// bus and handshake checks
//##############################
module dcache_assertions import dcache_pkg::*; (
    input logic    CLK,
    input logic    nRST,
    input logic    wb_cyc,
    input logic    wb_stb,
    input logic    wb_ack,
    input word_t   wb_adr,
    input dp_rsp_t dp_rsp
);

    int fail_count = 0;

    assert property (@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc)
        else begin
            $error("wishbone stb high without cyc");
            fail_count++;
        end

    // address held until the slave acks
    assert property (@(posedge CLK) disable iff (!nRST)
                     (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else begin
            $error("wishbone address or stb changed before ack");
            fail_count++;
        end

    assert property (@(posedge CLK) disable iff (!nRST) wb_cyc |-> !dp_rsp.hit)
        else begin
            $error("datapath hit while a bus cycle is open");
            fail_count++;
        end

endmodule

bind dcache_top dcache_assertions chk (.*);

// File: bench/dcache_tb.sv
`timescale 1ns/1ps
//##############################
// data cache testbench
//##############################
module dcache_tb import dcache_pkg::*; ();

    localparam int N_REQ   = 200;
    localparam int TIMEOUT = 400 * N_REQ + 600;

    logic    CLK, nRST, halt, flushed;
    dp_req_t dp_req;
    dp_rsp_t dp_rsp;
    word_t   hit_count;
    logic    wb_cyc, wb_stb, wb_we, wb_ack;
    word_t   wb_adr, wb_dat_o, wb_dat_i;

    // one predicted bus transfer
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t data;
    } xfer_t;

    word_t       bus_mem [word_t];     // behind the slave
    word_t       mdl_mem [word_t];     // memory as the model sees it
    word_t       ref_mem [word_t];     // latest datapath writes
    set_t        mdl_sets [SETS];
    xfer_t       expected [$];
    logic [31:0] stim_seed = 32'd69323;
    logic [31:0] wait_seed = 32'd69323;
    int          reset_errs, rw_errs, bus_errs, count_errs, flush_errs;
    int          tests_run, tests_failed, exp_hits, cycles;

    clock_gen clk_gen (.CLK(CLK), .nRST(nRST));

    dcache_top uut (.*);

    function automatic logic [31:0] lcg_next(inout logic [31:0] s);
        s = s * 32'd1103515245 + 32'd12345;
        return s;
    endfunction

    // unwritten memory content, spread over every address bit
    function automatic word_t mem_pattern(input word_t a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t word_addr(input logic [TAG_W-1:0] tag,
                                        input logic [IDX_W-1:0] idx,
                                        input logic             w);
        return {tag, idx, w, 2'b00};
    endfunction

    task automatic push_expect(input logic we, input word_t a, input word_t d);
        xfer_t x;
        x.we   = we;
        x.addr = a;
        x.data = d;
        expected.push_back(x);
    endtask

    task automatic write_back_frame(input frame_t f, input logic [IDX_W-1:0] idx);
        word_t a;
        for (int b = 0; b < BLK_WORDS; b++) begin
            a = word_addr(f.tag, idx, b[0]);
            push_expect(1'b1, a, f.data[b]);
            mdl_mem[a] = f.data[b];
        end
    endtask

    // reference cache: refill into lru way, then the access itself
    task automatic model_access(input dp_req_t r, output logic was_hit);
        addr_t  a;
        frame_t f;
        logic   way;
        word_t  wa;
        a       = r.addr;
        way     = 1'b0;
        was_hit = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (mdl_sets[a.idx].frame[w].valid && mdl_sets[a.idx].frame[w].tag == a.tag) begin
                was_hit = 1'b1;
                way     = w[0];
            end
        end
        if (!was_hit) begin
            way = mdl_sets[a.idx].lru;
            f   = mdl_sets[a.idx].frame[way];
            if (f.valid && f.dirty) write_back_frame(f, a.idx);
            for (int b = 0; b < BLK_WORDS; b++) begin
                wa = word_addr(a.tag, a.idx, b[0]);
                push_expect(1'b0, wa, '0);
                f.data[b] = mdl_mem.exists(wa) ? mdl_mem[wa] : mem_pattern(wa);
            end
            f.valid = 1'b1;
            f.dirty = 1'b0;
            f.tag   = a.tag;
            mdl_sets[a.idx].frame[way] = f;
        end
        if (r.wen) begin
            mdl_sets[a.idx].frame[way].data[a.blkoff] = r.wdata;
            mdl_sets[a.idx].frame[way].dirty          = 1'b1;
        end
        mdl_sets[a.idx].lru = ~way;
    endtask

    task automatic model_flush();
        for (int p = 0; p < WAYS * SETS; p++) begin
            if (mdl_sets[p[3:1]].frame[p[0]].valid && mdl_sets[p[3:1]].frame[p[0]].dirty) begin
                write_back_frame(mdl_sets[p[3:1]].frame[p[0]], p[3:1]);
                mdl_sets[p[3:1]].frame[p[0]].dirty = 1'b0;
            end
        end
    endtask

    task automatic serve_transfer();
        xfer_t x;
        assert (expected.size() > 0) else begin
            $display("unexpected bus transfer to %h at %0t, none was predicted", wb_adr, $time);
            bus_errs++;
        end
        if (expected.size() > 0) begin
            x = expected.pop_front();
            assert (wb_we == x.we && wb_adr == x.addr && (!x.we || wb_dat_o == x.data)) else begin
                $display("error at %0t: bus we %b adr %h data %h, expected we %b adr %h data %h",
                         $time, wb_we, wb_adr, wb_dat_o, x.we, x.addr, x.data);
                bus_errs++;
            end
        end
        if (wb_we) bus_mem[wb_adr] = wb_dat_o;
        else wb_dat_i = bus_mem.exists(wb_adr) ? bus_mem[wb_adr] : mem_pattern(wb_adr);
    endtask

    // sample mid low phase, after the falling edge drive has settled
    task automatic wait_for_hit();
        #2;
        while (!dp_rsp.hit) begin
            @(negedge CLK);
            #2;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // wishbone slave with 0 to 3 wait cycles
    initial begin
        int wait_left;
        wait_left = -1;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        forever begin
            @(negedge CLK);
            if (wb_ack) begin
                wb_ack = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (wait_left < 0) wait_left = int'(lcg_next(wait_seed) >> 16) % 4;
                if (wait_left == 0) begin
                    serve_transfer();
                    wb_ack = 1'b1;
                end
                wait_left--;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the cache did not finish within %0d cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    initial begin
        dp_req_t     r;
        addr_t       a;
        logic        was_hit;
        word_t       exp_data;
        logic [31:0] rnd;
        dp_req = '0;
        halt   = 1'b0;
        for (int s = 0; s < SETS; s++) mdl_sets[s] = '0;
        @(posedge nRST);
        @(negedge CLK);

        assert (!wb_stb && !wb_cyc && !dp_rsp.hit && !flushed && hit_count == 0) else begin
            $display("error at %0t: not idle after reset, stb %b cyc %b hit %b flushed %b count %0d",
                     $time, wb_stb, wb_cyc, dp_rsp.hit, flushed, hit_count);
            reset_errs++;
        end
        report_test("reset", reset_errs);

        for (int i = 0; i < N_REQ; i++) begin
            rnd      = lcg_next(stim_seed);
            a.tag    = TAG_W'(32'h0012_3400 + 32'h0001_0ABC * rnd[17:16]);  // four tags
            a.idx    = rnd[20:18];
            a.blkoff = rnd[21];
            a.bytoff = 2'b00;
            r.ren    = !rnd[22];
            r.wen    = rnd[22];
            r.addr   = a;
            r.wdata  = lcg_next(stim_seed);
            exp_data = ref_mem.exists(word_t'(a)) ? ref_mem[word_t'(a)] : mem_pattern(word_t'(a));
            model_access(r, was_hit);
            if (was_hit) exp_hits++;
            if (r.wen) ref_mem[word_t'(a)] = r.wdata;
            dp_req = r;
            wait_for_hit();
            if (r.ren) begin
                assert (dp_rsp.rdata == exp_data) else begin
                    $display("error at %0t: read %h returned %h, expected %h",
                             $time, a, dp_rsp.rdata, exp_data);
                    rw_errs++;
                end
            end
            @(negedge CLK);
        end
        report_test("read_after_write", rw_errs);

        assert (hit_count == exp_hits) else begin
            $display("error at %0t: hit count %0d, expected %0d", $time, hit_count, exp_hits);
            count_errs++;
        end
        report_test("hit_count", count_errs);

        model_flush();
        dp_req = '0;
        halt   = 1'b1;
        while (!flushed) @(negedge CLK);
        assert (expected.size() == 0) else begin
            $display("flush ended with %0d predicted bus transfers never seen", expected.size());
            flush_errs++;
        end
        foreach (ref_mem[k]) begin
            assert (bus_mem.exists(k) && bus_mem[k] == ref_mem[k]) else begin
                $display("error at %0t: memory %h holds %h after flush, expected %h", $time, k,
                         bus_mem.exists(k) ? bus_mem[k] : mem_pattern(k), ref_mem[k]);
                flush_errs++;
            end
        end
        report_test("flush", flush_errs);
        report_test("eviction", bus_errs);

        $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures, %0d cycles",
                 tests_run, tests_run - tests_failed, tests_failed, uut.chk.fail_count, cycles);
        if (tests_failed == 0 && uut.chk.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
src/dcache_pkg.sv
src/dcache_store.sv
src/dcache_fsm.sv
src/wb_word_port.sv
src/dcache_top.sv
bench/clock_gen.sv
bench/dcache_assertions.sv
bench/dcache_tb.sv
